// ==== hw/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address and way geometry
`define DC_ADDR_W      32
`define DC_WAYS        4
`define DC_WAY_W       2

`define DC_INDEX_W     4    // 16 sets
`define DC_OFFSET_W    4    // byte offset within a line

// word select inside a line
`define DC_WORD_IDX_W  (`DC_OFFSET_W - 2)
`define DC_LINE_WORDS  (1 << (`DC_OFFSET_W - 2))

`define DC_TAG_W       (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)
`define DC_SETS        (1 << `DC_INDEX_W)

`endif

// ==== hw/dcache_pkg.sv ====
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    // one load or store from the core
    typedef struct packed {
        logic                  write;
        logic [`DC_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
        logic [3:0]            wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [7:0]            len;
    } axi_ar_t;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [7:0]            len;  // size is fixed at 4 bytes
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

endpackage

`default_nettype wire

// ==== hw/dcache_dp_ram.sv ====
`default_nettype none

`include "dcache_settings.svh"

// one entry per set, write port and read port share the clock
module dcache_dp_ram #(
    parameter type entry_t = logic [31:0]
) (
    input  wire                    clk,
    input  wire                    we,
    input  wire  [`DC_INDEX_W-1:0] waddr,
    input  entry_t                 wdata,
    input  wire                    re,
    input  wire  [`DC_INDEX_W-1:0] raddr,
    output entry_t                 rdata
);
    entry_t mem [`DC_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];  // holds while re is low
        end
    end

    a_no_x_write: assert property (@(posedge clk) we |-> !$isunknown(wdata))
        else $error("dcache_dp_ram: unknown write data at set %0d", waddr);

endmodule

`default_nettype wire

// ==== hw/dcache_way_lookup.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_way_lookup (
    input  dcache_pkg::tag_entry_t tags [`DC_WAYS],
    input  wire  [31:0]            words [`DC_WAYS][`DC_LINE_WORDS],
    input  wire  [`DC_ADDR_W-1:0]  addr,
    output logic                   hit,
    output logic [`DC_WAY_W-1:0]   hit_way,
    output logic [31:0]            hit_word
);
    logic [`DC_TAG_W-1:0]      addr_tag;
    logic [`DC_WORD_IDX_W-1:0] word_sel;
    logic [`DC_WAYS-1:0]       match;

    assign addr_tag = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign word_sel = addr[2 +: `DC_WORD_IDX_W];

    always_comb begin
        for (int i = 0; i < `DC_WAYS; i++) begin
            match[i] = tags[i].valid && (tags[i].tag == addr_tag);
        end
    end

    // one-hot match to way number
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `DC_WAYS; i++) begin
            if (match[i]) begin
                hit_way = hit_way | i[`DC_WAY_W-1:0];
            end
        end
    end

    assign hit      = |match;
    assign hit_word = words[hit_way][word_sel];  // don't care on a miss

    // a refill only goes to a missing tag, so a second copy means a broken fill path
    always_comb begin
        if (!$isunknown(match)) begin
            a_one_match: assert final ($onehot0(match))
                else $error("dcache_way_lookup: tag found in ways %b", match);
        end
    end

endmodule

`default_nettype wire

// ==== hw/dcache_repl_table.sv ====
`default_nettype none

`include "dcache_settings.svh"

// victim pointer and dirty bits, one row per set
module dcache_repl_table (
    input  wire                    clk,
    input  wire                    rst,
    input  wire  [`DC_INDEX_W-1:0] index,
    input  wire                    touch,
    input  wire  [`DC_WAY_W-1:0]   touch_way,
    input  wire                    set_dirty,
    input  wire                    clear_dirty,
    output logic [`DC_WAY_W-1:0]   victim_way,
    output logic                   victim_dirty
);
    logic [`DC_WAY_W-1:0] victim_q [`DC_SETS];
    logic [`DC_WAYS-1:0]  dirty_q  [`DC_SETS];

    assign victim_way   = victim_q[index];
    assign victim_dirty = dirty_q[index][victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                victim_q[s] <= '0;
                dirty_q[s]  <= '0;
            end
        end else begin
            // next victim is the inverse of the way just used
            if (touch) begin
                victim_q[index] <= ~touch_way;
            end
            if (set_dirty) begin
                dirty_q[index][touch_way] <= 1'b1;  // store hit
            end
            if (clear_dirty) begin
                dirty_q[index][victim_way] <= 1'b0;  // fresh line from memory
            end
        end
    end

    // dirty marking only comes with a store hit from the controller
    a_dirty_on_hit: assert property (@(posedge clk) disable iff (rst)
        set_dirty |-> touch && !clear_dirty)
        else $error("dcache_repl_table: dirty set without a hit");

endmodule

`default_nettype wire

// ==== hw/dcache_axi_burst.sv ====
`default_nettype none

`include "dcache_settings.svh"

// one line burst at a time, refill on AR/R, write-back on AW/W/B
module dcache_axi_burst (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       wb_start,
    input  wire                       fill_start,
    input  wire  [`DC_ADDR_W-1:0]     line_addr,
    input  wire  [31:0]               wb_word,
    output logic [`DC_WORD_IDX_W-1:0] wb_beat_idx,
    output logic                      fill_beat,
    output logic [`DC_WORD_IDX_W-1:0] fill_beat_idx,
    output logic [31:0]               fill_word,
    output logic                      burst_done,
    output dcache_pkg::axi_ar_t       ar,
    output logic                      arvalid,
    input  wire                       arready,
    input  dcache_pkg::axi_r_t        r,
    input  wire                       rvalid,
    output logic                      rready,
    output dcache_pkg::axi_aw_t       aw,
    output logic                      awvalid,
    input  wire                       awready,
    output dcache_pkg::axi_w_t        w,
    output logic                      wvalid,
    input  wire                       wready,
    input  wire                       bvalid,
    output logic                      bready
);
    typedef enum logic [2:0] {B_IDLE, B_AR, B_R, B_AW, B_W, B_B} bstate_t;

    bstate_t                   state;
    logic [`DC_ADDR_W-1:0]     addr_q;
    logic [`DC_WORD_IDX_W-1:0] beat;
    logic                      last_beat;
    logic                      start_ok;

    assign last_beat = &beat;
    assign start_ok  = (state == B_IDLE) || (bvalid && bready);  // refill may follow the B beat

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= B_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                B_IDLE: begin
                    beat <= '0;
                    if (fill_start) begin
                        state <= B_AR;
                    end else if (wb_start) begin
                        state <= B_AW;
                    end
                end
                B_AR: if (arready) state <= B_R;
                B_R: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (r.last) begin
                            state <= B_IDLE;
                        end
                    end
                end
                B_AW: if (awready) state <= B_W;
                B_W: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= B_B;
                        end
                    end
                    if (bvalid) begin
                        beat  <= '0;
                        state <= fill_start ? B_AR : B_IDLE;  // early response ends it too
                    end
                end
                B_B: begin
                    if (bvalid) begin
                        state <= fill_start ? B_AR : B_IDLE;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok && (fill_start || wb_start)) begin
            addr_q <= line_addr;
        end
    end

    assign ar      = '{addr: addr_q, len: 8'(`DC_LINE_WORDS - 1)};
    assign arvalid = (state == B_AR);
    assign rready  = (state == B_R);
    assign aw      = '{addr: addr_q, len: 8'(`DC_LINE_WORDS - 1)};
    assign awvalid = (state == B_AW);
    assign w       = '{data: wb_word, strb: 4'hf, last: last_beat};
    assign wvalid  = (state == B_W);
    assign bready  = (state == B_W) || (state == B_B);

    assign wb_beat_idx   = beat;
    assign fill_beat     = rvalid && rready;
    assign fill_beat_idx = beat;
    assign fill_word     = r.data;
    assign burst_done    = (fill_beat && r.last) || (bvalid && bready);

    a_rlast_pos: assert property (@(posedge clk) disable iff (rst)
        (rvalid && rready) |-> (r.last == last_beat))
        else $error("dcache_axi_burst: rlast on beat %0d", beat);

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        (fill_start || wb_start) |-> start_ok)
        else $error("dcache_axi_burst: burst start while busy");

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        req,
    input  dcache_pkg::cpu_req_t       cpu_req,
    input  wire                        hit,
    input  wire  [`DC_WAY_W-1:0]       hit_way,
    input  wire  [31:0]                hit_word,
    input  wire  [`DC_WAY_W-1:0]       victim_way,
    input  wire                        victim_dirty,
    input  dcache_pkg::tag_entry_t     tags [`DC_WAYS],
    input  wire                        fill_beat,
    input  wire  [`DC_WORD_IDX_W-1:0]  fill_beat_idx,
    input  wire  [31:0]                fill_word,
    input  wire                        burst_done,
    output logic                       ack,
    output logic [31:0]                rdata,
    output logic                       ram_re,
    output logic [`DC_INDEX_W-1:0]     ram_raddr,  // set address for both ports
    output logic [`DC_WAYS-1:0]        tag_we,
    output dcache_pkg::tag_entry_t     tag_wdata,
    output logic [`DC_WAYS-1:0][`DC_LINE_WORDS-1:0][3:0] data_we,
    output logic [31:0]                data_wdata,
    output logic                       touch,
    output logic [`DC_WAY_W-1:0]       touch_way,
    output logic                       set_dirty,
    output logic                       clear_dirty,
    output logic                       wb_start,
    output logic                       fill_start,
    output logic [`DC_ADDR_W-1:0]      line_addr
);
    // INIT sweeps the tag RAMs to invalid after reset
    typedef enum logic [2:0] {INIT, IDLE, LOOKUP, WRITEBACK, REFILL, REPLAY} state_t;

    state_t                    state;
    logic [`DC_INDEX_W-1:0]    init_cnt;
    logic [`DC_INDEX_W-1:0]    req_index;
    logic [`DC_TAG_W-1:0]      req_tag;
    logic [`DC_WORD_IDX_W-1:0] req_word;
    logic                      lookup_hit;
    logic                      lookup_miss;

    assign req_index   = cpu_req.addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_tag     = cpu_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_word    = cpu_req.addr[2 +: `DC_WORD_IDX_W];
    assign lookup_hit  = (state == LOOKUP) && hit;
    assign lookup_miss = (state == LOOKUP) && !hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= INIT;
            init_cnt <= '0;
        end else begin
            case (state)
                INIT: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (&init_cnt) state <= IDLE;
                end
                IDLE:      if (req) state <= LOOKUP;
                LOOKUP: begin
                    if (hit) begin
                        state <= IDLE;
                    end else begin
                        state <= victim_dirty ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: if (burst_done) state <= REFILL;
                REFILL:    if (burst_done) state <= REPLAY;
                REPLAY:    state <= LOOKUP;  // reread the filled line
                default:   state <= IDLE;
            endcase
        end
    end

    assign ack   = lookup_hit;
    assign rdata = hit_word;

    assign ram_re    = ((state == IDLE) && req) || (state == REPLAY);
    assign ram_raddr = (state == INIT) ? init_cnt : req_index;

    assign touch       = lookup_hit;
    assign touch_way   = hit_way;
    assign set_dirty   = lookup_hit && cpu_req.write;
    assign clear_dirty = (state == REFILL) && burst_done;

    assign wb_start   = lookup_miss && victim_dirty;
    assign fill_start = (lookup_miss && !victim_dirty) || ((state == WRITEBACK) && burst_done);
    assign line_addr  = wb_start ? {tags[victim_way].tag, req_index, {`DC_OFFSET_W{1'b0}}}
                                 : {req_tag, req_index, {`DC_OFFSET_W{1'b0}}};

    always_comb begin
        tag_we = '0;
        if (state == INIT) begin
            tag_we = '1;
        end else if (clear_dirty) begin
            tag_we[victim_way] = 1'b1;  // tag goes in with the last beat
        end
    end

    assign tag_wdata = (state == INIT) ? '0 : '{valid: 1'b1, tag: req_tag};

    // store hit merges strobed bytes, refill writes whole beats
    always_comb begin
        data_we = '0;
        if (set_dirty) begin
            data_we[hit_way][req_word] = cpu_req.wstrb;
        end else if ((state == REFILL) && fill_beat) begin
            data_we[victim_way][fill_beat_idx] = 4'hf;
        end
    end

    assign data_wdata = (state == REFILL) ? fill_word : cpu_req.wdata;

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (req && !ack) |=> req && $stable(cpu_req))
        else $error("dcache_ctrl: request dropped or changed before ack");

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  req,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 ack,
    output logic [31:0]          rdata,
    output dcache_pkg::axi_ar_t  ar,
    output logic                 arvalid,
    input  wire                  arready,
    input  dcache_pkg::axi_r_t   r,
    input  wire                  rvalid,
    output logic                 rready,
    output dcache_pkg::axi_aw_t  aw,
    output logic                 awvalid,
    input  wire                  awready,
    output dcache_pkg::axi_w_t   w,
    output logic                 wvalid,
    input  wire                  wready,
    input  wire                  bvalid,
    output logic                 bready
);
    logic                      hit, ram_re, touch, set_dirty, clear_dirty;
    logic                      victim_dirty, wb_start, fill_start;
    logic                      fill_beat, burst_done;
    logic [`DC_WAY_W-1:0]      hit_way, victim_way, touch_way;
    logic [31:0]               hit_word, data_wdata, fill_word;
    logic [`DC_INDEX_W-1:0]    ram_raddr;
    logic [`DC_WAYS-1:0]       tag_we;
    logic [`DC_ADDR_W-1:0]     line_addr;
    logic [`DC_WORD_IDX_W-1:0] wb_beat_idx, fill_beat_idx;
    logic [`DC_WAYS-1:0][`DC_LINE_WORDS-1:0][3:0] data_we;
    dcache_pkg::tag_entry_t    tag_wdata;
    dcache_pkg::tag_entry_t    tag_rd  [`DC_WAYS];
    logic [7:0]                byte_rd [`DC_WAYS][`DC_LINE_WORDS][4];
    logic [31:0]               word_rd [`DC_WAYS][`DC_LINE_WORDS];

    for (genvar i = 0; i < `DC_WAYS; i++) begin : g_way
        dcache_dp_ram #(.entry_t(dcache_pkg::tag_entry_t)) u_tag_ram (
            .clk, .we(tag_we[i]), .waddr(ram_raddr), .wdata(tag_wdata),
            .re(ram_re), .raddr(ram_raddr), .rdata(tag_rd[i]));
        for (genvar j = 0; j < `DC_LINE_WORDS; j++) begin : g_word
            for (genvar b = 0; b < 4; b++) begin : g_lane  // byte write per lane
                dcache_dp_ram #(.entry_t(logic [7:0])) u_data_ram (
                    .clk, .we(data_we[i][j][b]), .waddr(ram_raddr),
                    .wdata(data_wdata[8*b +: 8]), .re(ram_re), .raddr(ram_raddr),
                    .rdata(byte_rd[i][j][b]));
            end
            assign word_rd[i][j] = {byte_rd[i][j][3], byte_rd[i][j][2],
                                    byte_rd[i][j][1], byte_rd[i][j][0]};
        end
    end

    dcache_way_lookup u_lookup (.tags(tag_rd), .words(word_rd), .addr(cpu_req.addr),
        .hit, .hit_way, .hit_word);

    dcache_repl_table u_repl (.clk, .rst, .index(cpu_req.addr[`DC_OFFSET_W +: `DC_INDEX_W]),
        .touch, .touch_way, .set_dirty, .clear_dirty, .victim_way, .victim_dirty);

    dcache_ctrl u_ctrl (.clk, .rst, .req, .cpu_req, .hit, .hit_way, .hit_word,
        .victim_way, .victim_dirty, .tags(tag_rd), .fill_beat, .fill_beat_idx,
        .fill_word, .burst_done, .ack, .rdata, .ram_re, .ram_raddr, .tag_we, .tag_wdata,
        .data_we, .data_wdata, .touch, .touch_way, .set_dirty, .clear_dirty,
        .wb_start, .fill_start, .line_addr);

    // victim line stays on the RAM outputs for the whole write-back
    dcache_axi_burst u_burst (.clk, .rst, .wb_start, .fill_start, .line_addr,
        .wb_word(word_rd[victim_way][wb_beat_idx]), .wb_beat_idx, .fill_beat,
        .fill_beat_idx, .fill_word, .burst_done, .ar, .arvalid, .arready, .r, .rvalid,
        .rready, .aw, .awvalid, .awready, .w, .wvalid, .wready, .bvalid, .bready);

endmodule

`default_nettype wire

// ==== verification/dcache_axi_mem.sv ====
`default_nettype none

// AXI slave memory with random gaps on every channel it drives
module dcache_axi_mem (
    input  wire                 clk,
    input  wire                 rst,
    input  dcache_pkg::axi_ar_t ar,
    input  wire                 arvalid,
    output logic                arready,
    output dcache_pkg::axi_r_t  r,
    output logic                rvalid,
    input  wire                 rready,
    input  dcache_pkg::axi_aw_t aw,
    input  wire                 awvalid,
    output logic                awready,
    input  dcache_pkg::axi_w_t  w,
    input  wire                 wvalid,
    output logic                wready,
    output logic                bvalid,
    input  wire                 bready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [logic [29:0]];  // only words that were written
    integer      seed = 32'ha2d0ab83;
    logic        rd_busy;
    logic        wr_data;
    logic        wr_resp;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    logic [7:0]  rd_beat;
    logic [7:0]  rd_len;
    logic [7:0]  wr_beat;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a0000;  // untouched words
    endfunction

    // ready or valid offered three times out of four
    function automatic logic offer();
        return ($random(seed) & 3) != 0;
    endfunction

    task automatic store_beat(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [31:0] word;
        word = read_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[addr[31:2]] = word;
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_busy <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (!rd_busy) begin
            arready <= offer();
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                arready <= 1'b0;
                rd_addr <= ar.addr;
                rd_len  <= ar.len;
                rd_beat <= '0;
            end
        end else if (rvalid && rready && r.last) begin
            rd_busy <= 1'b0;
            rvalid  <= 1'b0;
        end else if (!rvalid || rready) begin
            rvalid <= 1'b0;  // gap unless a beat is offered
            if (offer()) begin
                rvalid  <= 1'b1;
                r       <= '{data: read_word(rd_addr + {rd_beat, 2'b00}),
                             last: rd_beat == rd_len};
                rd_beat <= rd_beat + 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            wr_data <= 1'b0;
            wr_resp <= 1'b0;
        end else if (wr_resp) begin
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                wr_resp <= 1'b0;
            end else begin
                bvalid <= bvalid || offer();
            end
        end else if (wr_data) begin
            wready <= offer();
            if (wvalid && wready) begin
                store_beat(wr_addr + {wr_beat, 2'b00}, w.data, w.strb);
                wr_beat <= wr_beat + 1'b1;
                if (w.last) begin
                    wr_data <= 1'b0;
                    wr_resp <= 1'b1;
                    wready  <= 1'b0;
                end
            end
        end else begin
            awready <= offer();
            if (awvalid && awready) begin
                awready <= 1'b0;
                wr_data <= 1'b1;
                wr_addr <= aw.addr;
                wr_beat <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/dcache_tb.sv ====
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES  = 4;
    localparam int SETTLE_CYCLES = 20;  // covers the tag sweep
    localparam int N_REQUESTS    = 224;
    localparam int MAX_CYCLES    = 40 * N_REQUESTS + RESET_CYCLES + SETTLE_CYCLES;
    localparam int LAST_BEAT     = 3;  // four beats per line

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req;
    dcache_pkg::cpu_req_t cpu_req;
    logic                 ack;
    logic [31:0]          rdata;
    dcache_pkg::axi_ar_t  ar;
    dcache_pkg::axi_r_t   r;
    dcache_pkg::axi_aw_t  aw;
    dcache_pkg::axi_w_t   w;
    logic                 arvalid, arready, rvalid, rready, awvalid, awready;
    logic                 wvalid, wready, bvalid, bready;

    logic [7:0]  shadow [2048];  // bytes 0x000 to 0x7ff
    logic [31:0] exp_rdata;
    logic        expect_hit;
    logic        req_seen;
    logic        aw_open;
    int          w_count;
    int          data_errors = 0;
    int          protocol_errors = 0;
    int          cycles = 0;
    integer      seed = 32'ha2d0ab83;

    always #10 clk = ~clk;

    dcache_top UUT (.clk, .rst, .req, .cpu_req, .ack, .rdata, .ar, .arvalid, .arready,
        .r, .rvalid, .rready, .aw, .awvalid, .awready, .w, .wvalid, .wready, .bvalid,
        .bready);

    dcache_axi_mem u_mem (.clk, .rst, .ar, .arvalid, .arready, .r, .rvalid, .rready,
        .aw, .awvalid, .awready, .w, .wvalid, .wready, .bvalid, .bready);

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return 32'((tag << (`DC_INDEX_W + `DC_OFFSET_W)) | (set << `DC_OFFSET_W) | (word << 2));
    endfunction

    // one request held until ack, then req drops
    task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input logic fast);
        @(negedge clk);
        cpu_req    = '{write: wr, addr: addr, wdata: data, wstrb: strb};
        expect_hit = fast;
        req        = 1'b1;
        do begin
            @(negedge clk);
        end while (!ack);
        @(negedge clk);
        req        = 1'b0;
        expect_hit = 1'b0;
    endtask

    task automatic finish_run(input logic timed_out);
        $display("errors: data %0d, protocol %0d, timeout %0d",
                 data_errors, protocol_errors, timed_out);
        if (data_errors == 0 && protocol_errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: requests still running after %0d cycles", cycles);
            finish_run(1'b1);
        end
    end

    // shadow follows each store at its ack
    always @(posedge clk) begin
        if (!rst && ack && cpu_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (cpu_req.wstrb[b]) begin
                    shadow[{cpu_req.addr[10:2], b[1:0]}] <= cpu_req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign exp_rdata = {shadow[{cpu_req.addr[10:2], 2'd3}], shadow[{cpu_req.addr[10:2], 2'd2}],
                        shadow[{cpu_req.addr[10:2], 2'd1}], shadow[{cpu_req.addr[10:2], 2'd0}]};

    always @(posedge clk) begin
        if (rst) begin
            req_seen <= 1'b0;
            aw_open  <= 1'b0;
            w_count  <= 0;
        end else begin
            if (req) req_seen <= 1'b1;
            if (awvalid && awready) begin
                aw_open <= 1'b1;
                w_count <= 0;
            end
            if (wvalid && wready) w_count <= w_count + 1;
            if (bvalid && bready) aw_open <= 1'b0;  // burst closed
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !req_seen |-> !(ack || arvalid || rready || awvalid || wvalid || bready))
        else begin
            protocol_errors++;
            $display("ack or an AXI valid or ready went high at %0t before any request", $time);
        end

    a_fast_hit: assert property (@(posedge clk) disable iff (rst)
        $rose(req) && expect_hit |=> ack)
        else begin
            protocol_errors++;
            $display("hit at %0t was not acknowledged one cycle after req", $time);
        end

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        ack && !cpu_req.write |-> rdata == exp_rdata)
        else begin
            data_errors++;
            $display("mismatch at %0t: rdata expected %h got %h",
                     $time, $sampled(exp_rdata), $sampled(rdata));
        end

    a_arlen: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> ar.len == 8'(LAST_BEAT))
        else begin
            protocol_errors++;
            $display("mismatch at %0t: arlen expected %0d got %0d",
                     $time, LAST_BEAT, $sampled(ar.len));
        end

    a_awlen: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> aw.len == 8'(LAST_BEAT))
        else begin
            protocol_errors++;
            $display("mismatch at %0t: awlen expected %0d got %0d",
                     $time, LAST_BEAT, $sampled(aw.len));
        end

    a_ar_aligned: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> ar.addr[`DC_OFFSET_W-1:0] == '0)
        else begin
            protocol_errors++;
            $display("read burst address at %0t is not line-aligned", $time);
        end

    a_aw_aligned: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> aw.addr[`DC_OFFSET_W-1:0] == '0)
        else begin
            protocol_errors++;
            $display("write burst address at %0t is not line-aligned", $time);
        end

    a_wlast: assert property (@(posedge clk) disable iff (rst)
        wvalid && wready |-> w.last == (w_count == LAST_BEAT))
        else begin
            protocol_errors++;
            $display("mismatch at %0t: wlast expected %0d got %0d",
                     $time, $sampled(w_count) == LAST_BEAT, $sampled(w.last));
        end

    a_w_after_aw: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> aw_open)
        else begin
            protocol_errors++;
            $display("write data offered at %0t before the AW handshake", $time);
        end

    initial begin
        logic [31:0] pat;
        logic [31:0] rnd;
        for (int a = 0; a < 2048; a += 4) begin
            pat = 32'(a) ^ 32'h5a5a0000;
            for (int b = 0; b < 4; b++) begin
                shadow[a + b] = pat[8*b +: 8];
            end
        end
        rst        = 1'b1;
        req        = 1'b0;
        cpu_req    = '0;
        expect_hit = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (SETTLE_CYCLES) @(negedge clk);

        // miss, then a quick hit in the same line
        access(1'b0, make_addr(1, 2, 1), '0, '0, 1'b0);
        access(1'b0, make_addr(1, 2, 3), '0, '0, 1'b1);

        // byte merges on a resident line and on a missing one
        access(1'b1, make_addr(1, 2, 0), 32'h11223344, 4'b0011, 1'b0);
        access(1'b1, make_addr(1, 2, 0), 32'haabbccdd, 4'b1100, 1'b0);
        access(1'b1, make_addr(1, 2, 2), 32'h00ee0000, 4'b0100, 1'b0);
        access(1'b0, make_addr(1, 2, 0), '0, '0, 1'b1);
        access(1'b0, make_addr(1, 2, 2), '0, '0, 1'b1);
        access(1'b1, make_addr(2, 3, 1), 32'h99000077, 4'b1001, 1'b0);
        access(1'b0, make_addr(2, 3, 1), '0, '0, 1'b1);

        // five lines in set 5 push dirty lines out and back
        for (int t = 0; t < 5; t++) begin
            access(1'b1, make_addr(t + 3, 5, t % 4), 32'hc0de0000 + t, 4'hf, 1'b0);
        end
        for (int t = 0; t < 5; t++) begin
            access(1'b0, make_addr(t + 3, 5, t % 4), '0, '0, 1'b0);
            access(1'b0, make_addr(t + 3, 5, 3 - t % 4), '0, '0, 1'b0);
        end

        // random mix over tags 0..7 and sets 0..7
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            access(rnd[0], make_addr(rnd[3:1], rnd[6:4], rnd[8:7]), $random(seed),
                   rnd[12:9], 1'b0);
        end
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== dcache.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_dp_ram.sv
hw/dcache_way_lookup.sv
hw/dcache_repl_table.sv
hw/dcache_axi_burst.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_axi_mem.sv
verification/dcache_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = dcache_tb
FILELIST   = dcache.f
OBJ_DIR    = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)
